//--- common/arith_types_pkg.sv
package arith_types_pkg;

    // magnitude width of each operand
    localparam int op_width = 32;

    // one request into the core
    typedef struct packed {
        logic [4:0]          op;
        logic [op_width-1:0] a_mag;
        logic [op_width-1:0] b_mag;
        logic                a_sign;
        logic                b_sign;
    } fpu_req_t;

    // one response out of the core
    typedef struct packed {
        // remainder or upper product word
        logic [op_width-1:0] hi;
        // quotient or lower product word
        logic [op_width-1:0] lo;
        logic                sign;
        logic                div_zero;
        logic                illegal_op;
    } fpu_rsp_t;

endpackage

//--- common/fpu_ctrl_pkg.sv
package fpu_ctrl_pkg;

    // operation codes the core knows about
    // anything else gets the illegal flag
    typedef enum logic [4:0] {
        op_mul = 5'd6,
        op_div = 5'd7
    } fpu_op_e;

    // sequencer states
    typedef enum logic [1:0] {
        idle,
        run,
        reply
    } seq_state_e;

endpackage

//--- flist.f
+incdir+tb
common/arith_types_pkg.sv
common/fpu_ctrl_pkg.sv
fpu_div/fpu_div.sv
fpu_mul/fpu_mul.sv
verilog/fpu_seq.sv
verilog/fpu_arith_top.sv
tb/tb_fpu_arith.sv

//--- fpu_div/fpu_div.sv
`timescale 1ns/1ps

module fpu_div
    import arith_types_pkg::*;
(
    input  logic                clk,
    input  logic                nrst,
    input  logic                start,
    input  logic [op_width-1:0] dividend,
    input  logic [op_width-1:0] divisor,
    output logic [op_width-1:0] quotient,
    output logic [op_width-1:0] remainder,
    output logic                div_zero,
    output logic                done
);

    typedef enum logic [1:0] {
        idle,
        divide,
        finish
    } div_state_e;

    div_state_e state;
    logic [4:0] iter_cnt;

    // partial remainder in the upper half
    // quotient bits shift in from the bottom
    logic [2*op_width-1:0] prem;
    logic [op_width-1:0]   divisor_q;

    // upper half after the shift, one bit wider
    logic [op_width:0] trial_hi;
    logic [op_width:0] diff;
    logic              trial_ok;

    assign trial_hi = prem[2*op_width-1:op_width-1];
    assign diff     = trial_hi - {1'b0, divisor_q};
    assign trial_ok = (trial_hi >= {1'b0, divisor_q});

    // control fsm
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state    <= idle;
            iter_cnt <= '0;
            div_zero <= 1'b0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state    <= divide;
                        iter_cnt <= '0;
                        // flag comes from the divisor being latched
                        div_zero <= (divisor == '0);
                    end
                end
                divide: begin
                    iter_cnt <= iter_cnt + 5'd1;
                    // 32 quotient bits, last one on count 31
                    if (iter_cnt == 5'd31) begin
                        state <= finish;
                    end
                end
                finish: begin
                    done  <= 1'b1;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            prem      <= {{op_width{1'b0}}, dividend};
            divisor_q <= divisor;
        end else if (state == divide) begin
            if (trial_ok) begin
                // subtract fits, quotient bit 1
                prem <= {diff[op_width-1:0], prem[op_width-2:0], 1'b1};
            end else begin
                // restore, quotient bit 0
                prem <= {prem[2*op_width-2:0], 1'b0};
            end
        end
    end

    assign quotient  = prem[op_width-1:0];
    assign remainder = prem[2*op_width-1:op_width];

endmodule

//--- fpu_mul/fpu_mul.sv
`timescale 1ns/1ps

module fpu_mul
    import arith_types_pkg::*;
(
    input  logic                clk,
    input  logic                nrst,
    input  logic                start,
    input  logic [op_width-1:0] multiplicand,
    input  logic [op_width-1:0] multiplier,
    output logic [op_width-1:0] product_hi,
    output logic [op_width-1:0] product_lo,
    output logic                done
);

    typedef enum logic [1:0] {
        idle,
        multiply,
        finish
    } mul_state_e;

    mul_state_e state;
    logic [4:0] iter_cnt;

    logic [2*op_width-1:0] acc;
    logic [op_width-1:0]   mcand_q;
    // shifts right, bit 0 is the current multiplier bit
    logic [op_width-1:0]   mplier_q;
    // multiplicand moved up to the current bit position
    logic [2*op_width-1:0] addend;

    assign addend = {{op_width{1'b0}}, mcand_q} << iter_cnt;

    // control fsm
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state    <= idle;
            iter_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state    <= multiply;
                        iter_cnt <= '0;
                    end
                end
                multiply: begin
                    iter_cnt <= iter_cnt + 5'd1;
                    if (iter_cnt == 5'd31) begin
                        state <= finish;
                    end
                end
                finish: begin
                    done  <= 1'b1;
                    state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            acc      <= '0;
            mcand_q  <= multiplicand;
            mplier_q <= multiplier;
        end else if (state == multiply) begin
            // partial product only for a set bit
            if (mplier_q[0]) begin
                acc <= acc + addend;
            end
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product_hi = acc[2*op_width-1:op_width];
    assign product_lo = acc[op_width-1:0];

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fpu_arith -f flist.f -o sim_fpu_arith \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/sim_fpu_arith > sim.log 2>&1
cat sim.log

# the log decides pass or fail
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "no pass line in log"; exit 1; }
exit 0

//--- tb/tb_fpu_ref.svh
// expected response, built straight from the arithmetic rules
function automatic fpu_rsp_t expected_response(input fpu_req_t r);
    fpu_rsp_t    e;
    logic [63:0] prod;
    e = '0;
    if (r.op == op_div) begin
        e.sign = r.a_sign ^ r.b_sign;
        if (r.b_mag == '0) begin
            // zero divisor gives all ones quotient and the dividend back
            e.div_zero = 1'b1;
            e.lo       = '1;
            e.hi       = r.a_mag;
        end else begin
            e.lo = r.a_mag / r.b_mag;
            e.hi = r.a_mag % r.b_mag;
        end
    end else if (r.op == op_mul) begin
        prod   = 64'(r.a_mag) * 64'(r.b_mag);
        e.hi   = prod[63:32];
        e.lo   = prod[31:0];
        e.sign = r.a_sign ^ r.b_sign;
    end else begin
        // words and sign stay zero
        e.illegal_op = 1'b1;
    end
    return e;
endfunction

// cycles from the accepting edge to rsp_valid
function automatic logic [31:0] expected_latency(input logic [4:0] op);
    if (op == op_div || op == op_mul) begin
        return 32'd35;
    end
    return 32'd1;
endfunction

// lcg step with numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] expected);
    if (got !== expected) begin
        $display("FAILED %s: got %h, expected %h", name, got, expected);
        end_in_failure();
    end
endtask

//--- tb/tb_fpu_arith.sv
`timescale 1ns/1ps

module tb_fpu_arith
    import arith_types_pkg::*;
    import fpu_ctrl_pkg::*;
();

    logic     clk;
    logic     nrst;
    logic     req_valid;
    fpu_req_t req;
    logic     rsp_valid;
    fpu_rsp_t rsp;
    logic     busy;

    // requests in flight and the edge each one was taken on
    fpu_req_t    exp_q[$];
    logic [31:0] acc_q[$];
    logic [31:0] cycle_cnt;
    logic [31:0] rand_state;

    task automatic end_in_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    `include "tb_fpu_ref.svh"

    fpu_arith_top dut0 (
        .clk       (clk),
        .nrst      (nrst),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .busy      (busy)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // cycle count, held at zero during reset
    always @(posedge clk) begin
        if (!nrst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
        end
    end

    function automatic fpu_req_t make_request(input logic [4:0] op, input logic [31:0] a,
                                              input logic [31:0] b, input logic sa,
                                              input logic sb);
        fpu_req_t r;
        r.op     = op;
        r.a_mag  = a;
        r.b_mag  = b;
        r.a_sign = sa;
        r.b_sign = sb;
        return r;
    endfunction

    task automatic make_random_request(output fpu_req_t r);
        logic [31:0] pick;
        logic [31:0] shift;
        rand_state = lcg_next(rand_state);
        pick = rand_state;
        rand_state = lcg_next(rand_state);
        r.a_mag = rand_state;
        rand_state = lcg_next(rand_state);
        r.b_mag = rand_state;
        rand_state = lcg_next(rand_state);
        shift = rand_state;
        r.a_sign = pick[17];
        r.b_sign = pick[18];
        if (pick[31:29] < 3'd3) begin
            r.op = op_mul;
        end else if (pick[31:29] < 3'd6) begin
            r.op = op_div;
            // narrow divisors for bigger quotients and an occasional zero
            r.b_mag = r.b_mag >> shift[31:27];
            if (shift[26:24] == 3'd0) begin
                r.b_mag = '0;
            end
        end else begin
            // any code including the legal ones
            r.op = pick[26:22];
        end
    endtask

    // called at a falling edge with busy low
    task automatic drive_request(input fpu_req_t r);
        req       = r;
        req_valid = 1'b1;
        exp_q.push_back(r);
        acc_q.push_back(cycle_cnt + 32'd1);
    endtask

    // returns on the falling edge where rsp_valid is high
    task automatic wait_response();
        int n;
        @(negedge clk);
        req_valid = 1'b0;
        n = 1;
        while (!rsp_valid && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_valid) begin
            $display("timeout: no rsp_valid within 100 cycles of a request");
            end_in_failure();
        end
    endtask

    task automatic run_request(input fpu_req_t r);
        drive_request(r);
        wait_response();
    endtask

    // compare each response with the reference
    always @(negedge clk) begin : compare_rsp
        fpu_req_t    got_req;
        fpu_rsp_t    want;
        logic [31:0] acc_edge;
        if (nrst && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("rsp_valid pulsed with no request pending");
                end_in_failure();
            end
            got_req  = exp_q.pop_front();
            acc_edge = acc_q.pop_front();
            want     = expected_response(got_req);
            check_value("rsp.hi", 64'(rsp.hi), 64'(want.hi));
            check_value("rsp.lo", 64'(rsp.lo), 64'(want.lo));
            check_value("rsp.sign", 64'(rsp.sign), 64'(want.sign));
            check_value("rsp.div_zero", 64'(rsp.div_zero), 64'(want.div_zero));
            check_value("rsp.illegal_op", 64'(rsp.illegal_op), 64'(want.illegal_op));
            check_value("latency", 64'(cycle_cnt - acc_edge),
                        64'(expected_latency(got_req.op)));
            // busy drops in the reply cycle
            check_value("busy", 64'(busy), 64'd0);
        end
    end

    initial begin
        fpu_req_t r;
        clk        = 1'b0;
        nrst       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rand_state = 32'd10809;
        repeat (10) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        // quiet outputs out of reset
        check_value("busy", 64'(busy), 64'd0);
        check_value("rsp_valid", 64'(rsp_valid), 64'd0);
        check_value("rsp.hi", 64'(rsp.hi), 64'd0);
        check_value("rsp.lo", 64'(rsp.lo), 64'd0);
        check_value("rsp flags", 64'({rsp.sign, rsp.div_zero, rsp.illegal_op}), 64'd0);

        // fixed divisions including a dividend below the divisor
        run_request(make_request(op_div, 32'd100, 32'd7, 1'b1, 1'b0));
        run_request(make_request(op_div, 32'hffff_ffff, 32'd1, 1'b0, 1'b0));
        run_request(make_request(op_div, 32'd5, 32'd9, 1'b0, 1'b1));
        run_request(make_request(op_div, 32'h8000_0000, 32'h8000_0000, 1'b1, 1'b1));
        run_request(make_request(op_div, 32'hdead_beef, 32'h0000_1234, 1'b1, 1'b0));

        // fixed products and a few random ones
        run_request(make_request(op_mul, 32'hffff_ffff, 32'hffff_ffff, 1'b1, 1'b0));
        run_request(make_request(op_mul, 32'd0, 32'h1234_5678, 1'b1, 1'b1));
        run_request(make_request(op_mul, 32'd12345, 32'd6789, 1'b0, 1'b1));
        run_request(make_request(op_mul, 32'd1, 32'h8000_0001, 1'b0, 1'b0));
        for (int i = 0; i < 8; i++) begin
            make_random_request(r);
            r.op = op_mul;
            run_request(r);
        end

        // divide by zero
        run_request(make_request(op_div, 32'h1234_5678, 32'd0, 1'b0, 1'b1));
        run_request(make_request(op_div, 32'd0, 32'd0, 1'b1, 1'b1));

        // codes other than 6 and 7
        run_request(make_request(5'd0, 32'd11, 32'd22, 1'b1, 1'b0));
        run_request(make_request(5'd31, 32'hffff_ffff, 32'd3, 1'b0, 1'b1));
        run_request(make_request(5'd5, 32'd4, 32'd2, 1'b1, 1'b1));
        run_request(make_request(5'd8, 32'd9, 32'd0, 1'b0, 1'b0));

        // strobe while busy must be dropped
        drive_request(make_request(op_div, 32'd1000, 32'd3, 1'b0, 1'b1));
        @(negedge clk);
        req_valid = 1'b0;
        repeat (4) @(negedge clk);
        check_value("busy", 64'(busy), 64'd1);
        req       = make_request(op_mul, 32'd77, 32'd88, 1'b1, 1'b1);
        req_valid = 1'b1;
        wait_response();
        // a stray response would show up in the compare process
        repeat (60) @(negedge clk);
        check_value("busy", 64'(busy), 64'd0);

        // back to back random mix
        for (int i = 0; i < 200; i++) begin
            make_random_request(r);
            run_request(r);
        end

        repeat (4) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- verilog/fpu_arith_top.sv
`timescale 1ns/1ps

module fpu_arith_top
    import arith_types_pkg::*;
    import fpu_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     nrst,
    input  logic     req_valid,
    input  fpu_req_t req,
    output logic     rsp_valid,
    output fpu_rsp_t rsp,
    output logic     busy
);

    // sequencer to units
    logic                div_start;
    logic                mul_start;
    logic [op_width-1:0] a_mag;
    logic [op_width-1:0] b_mag;

    // units back to sequencer
    logic                div_done;
    logic [op_width-1:0] div_quot;
    logic [op_width-1:0] div_rem;
    logic                div_zero;
    logic                mul_done;
    logic [op_width-1:0] mul_hi;
    logic [op_width-1:0] mul_lo;

    fpu_seq seq0 (
        .clk       (clk),
        .nrst      (nrst),
        .req_valid (req_valid),
        .req       (req),
        .div_start (div_start),
        .mul_start (mul_start),
        .a_mag     (a_mag),
        .b_mag     (b_mag),
        .div_done  (div_done),
        .div_quot  (div_quot),
        .div_rem   (div_rem),
        .div_zero  (div_zero),
        .mul_done  (mul_done),
        .mul_hi    (mul_hi),
        .mul_lo    (mul_lo),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .busy      (busy)
    );

    // a is the dividend, b the divisor
    fpu_div div0 (
        .clk       (clk),
        .nrst      (nrst),
        .start     (div_start),
        .dividend  (a_mag),
        .divisor   (b_mag),
        .quotient  (div_quot),
        .remainder (div_rem),
        .div_zero  (div_zero),
        .done      (div_done)
    );

    fpu_mul mul0 (
        .clk          (clk),
        .nrst         (nrst),
        .start        (mul_start),
        .multiplicand (a_mag),
        .multiplier   (b_mag),
        .product_hi   (mul_hi),
        .product_lo   (mul_lo),
        .done         (mul_done)
    );

endmodule

//--- verilog/fpu_seq.sv
`timescale 1ns/1ps

module fpu_seq
    import arith_types_pkg::*;
    import fpu_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                nrst,
    input  logic                req_valid,
    input  fpu_req_t            req,
    output logic                div_start,
    output logic                mul_start,
    output logic [op_width-1:0] a_mag,
    output logic [op_width-1:0] b_mag,
    input  logic                div_done,
    input  logic [op_width-1:0] div_quot,
    input  logic [op_width-1:0] div_rem,
    input  logic                div_zero,
    input  logic                mul_done,
    input  logic [op_width-1:0] mul_hi,
    input  logic [op_width-1:0] mul_lo,
    output logic                rsp_valid,
    output fpu_rsp_t            rsp,
    output logic                busy
);

    seq_state_e state;
    seq_state_e state_nxt;
    fpu_op_e    op_q;
    logic       sign_q;
    logic       accept;
    fpu_rsp_t   rsp_nxt;

    // a strobe while busy is dropped
    assign accept    = req_valid && !busy;
    assign busy      = (state == run);
    assign rsp_valid = (state == reply);

    always_comb begin
        state_nxt = state;
        case (state)
            idle, reply: state_nxt = accept ? run : idle;
            run: begin
                case (op_q)
                    op_div:  if (div_done) state_nxt = reply;
                    op_mul:  if (mul_done) state_nxt = reply;
                    // unknown code, answer right away
                    default: state_nxt = reply;
                endcase
            end
            default: state_nxt = idle;
        endcase
    end

    // response words picked by the captured op
    always_comb begin
        rsp_nxt = '0;
        case (op_q)
            op_div: begin
                rsp_nxt.hi       = div_rem;
                rsp_nxt.lo       = div_quot;
                rsp_nxt.sign     = sign_q;
                rsp_nxt.div_zero = div_zero;
            end
            op_mul: begin
                rsp_nxt.hi   = mul_hi;
                rsp_nxt.lo   = mul_lo;
                rsp_nxt.sign = sign_q;
            end
            // words and sign stay zero
            default: rsp_nxt.illegal_op = 1'b1;
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state     <= idle;
            div_start <= 1'b0;
            mul_start <= 1'b0;
            rsp       <= '0;
        end else begin
            state     <= state_nxt;
            // one-cycle start right after capture
            div_start <= accept && (req.op == op_div);
            mul_start <= accept && (req.op == op_mul);
            // rsp holds until the next reply
            if (state_nxt == reply) begin
                rsp <= rsp_nxt;
            end
        end
    end

    // captured request
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= fpu_op_e'(req.op);
            a_mag  <= req.a_mag;
            b_mag  <= req.b_mag;
            sign_q <= req.a_sign ^ req.b_sign;
        end
    end

endmodule
